/* recovery_params.svh */
// Sizes and codes are fixed at elaboration; register lengths must match the bank read map
`ifndef RECOVERY_PARAMS_SVH
`define RECOVERY_PARAMS_SVH

// Indirect image FIFO depth in 32-bit words
`define REC_FIFO_DEPTH 16

// Reported in INDIRECT_FIFO_STATUS word 4
`define REC_MAX_XFER_SIZE 64

// Register lengths in bytes
`define REC_LEN_DEVICE_STATUS 7
`define REC_LEN_DEVICE_RESET 3
`define REC_LEN_RECOVERY_CTRL 3
`define REC_LEN_FIFO_CTRL 6
`define REC_LEN_FIFO_STATUS 20

// Special byte codes
`define REC_ACTIVATE_CODE 8'h0F
`define REC_FIFO_RESET_CODE 8'h01

// Commands from this code on need recovery mode
`define REC_FIRST_RECOVERY_CMD 40

`endif

/* recovery_pkg.sv */
// Only the kept recovery commands are encoded; other codes are rejected by the controller
package recovery_pkg;

  // Plain vectors with a meaning
  typedef logic [7:0] byte_t;
  typedef logic [31:0] word_t;
  typedef logic [15:0] len_t;
  typedef logic [7:0] cmd_code_t;

  // FIFO index as reported in status, always 32 bits
  typedef logic [31:0] fifo_idx_t;

  // Supported recovery commands
  typedef enum cmd_code_t {
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } cmd_e;

  // Command FSM
  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    FifoWrite,
    CsrRead,
    CsrReadData,
    Error,
    Done
  } ctrl_state_e;

  // DEVICE_STATUS protocol error byte
  typedef enum byte_t {
    PROT_OK  = 8'h00,
    PROT_CRC = 8'h04
  } prot_err_e;

endpackage

/* rec_csr_if.sv */
// start and done are single-cycle pulses; rdata and rd_len are combinational from the bank
`timescale 1ns/1ps

interface rec_csr_if import recovery_pkg::*; ();

  // Controller to bank
  logic      start;
  cmd_code_t cmd;
  logic      crc_err;
  logic      wr_stb;
  word_t     wdata;
  logic      done;

  // Bank to serializer
  word_t rdata;
  len_t  rd_len;

  // Serializer to bank, word advance
  logic rd_next;

  modport ctrl(output start, cmd, crc_err, wr_stb, wdata, done);
  modport bank(input start, cmd, crc_err, wr_stb, wdata, done, rd_next, output rdata, rd_len);
  modport ser(input rdata, rd_len, output rd_next);

endinterface

/* recovery_ctrl.sv */
// One receive-queue request outstanding at a time; words past a register are fetched and dropped
`timescale 1ns/1ps
`include "recovery_params.svh"

module recovery_ctrl import recovery_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmd_valid_i,
  input  logic      cmd_is_rd_i,
  input  cmd_code_t cmd_code_i,
  input  len_t      cmd_len_i,
  input  logic      cmd_error_i,
  output logic      cmd_done_o,
  input  logic      recovery_mode_i,
  input  logic      host_abort_i,
  output logic      tti_rx_rreq_o,
  input  logic      tti_rx_rack_i,
  input  word_t     tti_rx_rdata_i,
  output logic      rx_queue_clr_o,
  output logic      res_valid_o,
  input  logic      res_ready_i,
  output logic      res_dvalid_o,
  input  logic      res_dready_i,
  input  logic      last_beat_i,
  output logic      fifo_wr_o,
  output word_t     fifo_wdata_o,
  rec_csr_if.ctrl   csr
);

  ctrl_state_e state_q, state_d;
  logic accept;
  logic known;
  logic illegal;
  len_t words_init;
  len_t words_q;
  logic rreq_q;
  logic pend_q;

  assign accept = (state_q == Idle) && cmd_valid_i;
  assign known = cmd_code_i inside {CMD_DEVICE_STATUS, CMD_DEVICE_RESET, CMD_RECOVERY_CTRL,
                                    CMD_INDIRECT_FIFO_CTRL, CMD_INDIRECT_FIFO_STATUS,
                                    CMD_INDIRECT_FIFO_DATA};
  assign illegal = cmd_error_i || !known
                || (cmd_is_rd_i && (cmd_code_i == CMD_INDIRECT_FIFO_DATA))
                || (!recovery_mode_i && (cmd_code_i >= cmd_code_t'(`REC_FIRST_RECOVERY_CMD)));

  // Payload words, rounded up
  assign words_init = {2'b00, cmd_len_i[15:2]} + len_t'(|cmd_len_i[1:0]);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (accept) begin
          if (illegal) state_d = Error;
          else if (cmd_is_rd_i) state_d = CsrRead;
          else if (cmd_len_i == '0) state_d = Done;
          else if (cmd_code_i == CMD_INDIRECT_FIFO_DATA) state_d = FifoWrite;
          else state_d = CsrWrite;
        end
      end
      CsrWrite, FifoWrite: begin
        if (tti_rx_rack_i && (words_q == len_t'(1))) state_d = Done;
      end
      CsrRead: begin
        if (res_ready_i) state_d = CsrReadData;
      end
      CsrReadData: begin
        if (host_abort_i) state_d = Error;
        else if (last_beat_i) state_d = Done;
      end
      Error: state_d = Done;
      Done: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      words_q <= '0;
      rreq_q <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) words_q <= words_init;
      else if (tti_rx_rack_i && (state_q inside {CsrWrite, FifoWrite})) words_q <= words_q - 1'b1;
      // Next request on entry, or after each ack that keeps us writing
      rreq_q <= (state_d inside {CsrWrite, FifoWrite}) && ((state_q == Idle) || tti_rx_rack_i);
      if (tti_rx_rack_i) pend_q <= 1'b0;
      else if (rreq_q) pend_q <= 1'b1;
    end
  end

  assign tti_rx_rreq_o = rreq_q;
  assign rx_queue_clr_o = (state_q == Error);
  assign cmd_done_o = (state_q == Done);
  assign res_valid_o = (state_q == CsrRead);
  assign res_dvalid_o = (state_q == CsrReadData);

  // Payload routing
  assign fifo_wr_o = (state_q == FifoWrite) && tti_rx_rack_i;
  assign fifo_wdata_o = tti_rx_rdata_i;
  assign csr.wr_stb = (state_q == CsrWrite) && tti_rx_rack_i;
  assign csr.wdata = tti_rx_rdata_i;

  // Bank latches these on start
  assign csr.start = accept;
  assign csr.cmd = cmd_code_i;
  assign csr.crc_err = cmd_error_i;
  assign csr.done = (state_q == Done);

  a_rack_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tti_rx_rack_i |-> (pend_q || rreq_q));

  a_idle_exit_on_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((state_q == Idle) && !csr.start) |=> (state_q == Idle));

endmodule

/* recovery_csr_bank.sv */
// Only DEVICE_RESET, RECOVERY_CTRL and FIFO_CTRL are writable; status reads reflect live FIFO state
`timescale 1ns/1ps
`include "recovery_params.svh"

module recovery_csr_bank import recovery_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  rec_csr_if.bank   csr,
  input  logic      fifo_full_i,
  input  logic      fifo_empty_i,
  input  fifo_idx_t fifo_wr_idx_i,
  input  fifo_idx_t fifo_rd_idx_i,
  output logic      fifo_clr_o,
  output logic      image_activated_o
);

  cmd_code_t  cmd_q;
  logic       crc_q;
  logic [2:0] word_idx_q;
  len_t       reg_len;
  logic [3:0] byte_en;
  prot_err_e  prot_err_q;
  byte_t [2:0] dev_reset_q;
  byte_t [2:0] rec_ctrl_q;
  byte_t      fifo_cms_q;
  byte_t      fifo_reset_q;
  word_t      image_size_q;

  // Command latch and word index, saturating past the longest register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '0;
      crc_q <= 1'b0;
      word_idx_q <= '0;
    end else if (csr.start) begin
      cmd_q <= csr.cmd;
      crc_q <= csr.crc_err;
      word_idx_q <= '0;
    end else if ((csr.wr_stb || csr.rd_next) && (word_idx_q != 3'd7)) begin
      word_idx_q <= word_idx_q + 1'b1;
    end
  end

  always_comb begin
    case (cmd_q)
      CMD_DEVICE_STATUS: reg_len = len_t'(`REC_LEN_DEVICE_STATUS);
      CMD_DEVICE_RESET: reg_len = len_t'(`REC_LEN_DEVICE_RESET);
      CMD_RECOVERY_CTRL: reg_len = len_t'(`REC_LEN_RECOVERY_CTRL);
      CMD_INDIRECT_FIFO_CTRL: reg_len = len_t'(`REC_LEN_FIFO_CTRL);
      CMD_INDIRECT_FIFO_STATUS: reg_len = len_t'(`REC_LEN_FIFO_STATUS);
      default: reg_len = '0;
    endcase
  end
  assign csr.rd_len = reg_len;

  // A byte is written only if it lies inside the register
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_en[b] = csr.wr_stb && (len_t'({word_idx_q, 2'(b)}) < reg_len);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prot_err_q <= PROT_OK;
      dev_reset_q <= '0;
      rec_ctrl_q <= '0;
      fifo_cms_q <= '0;
      fifo_reset_q <= '0;
      image_size_q <= '0;
    end else begin
      if (csr.done) prot_err_q <= crc_q ? PROT_CRC : PROT_OK;
      // RESET byte clears itself the cycle after it is set
      if (fifo_reset_q != '0) fifo_reset_q <= '0;
      case (cmd_q)
        CMD_DEVICE_RESET: begin
          for (int b = 0; b < 3; b++) begin
            if (byte_en[b]) dev_reset_q[b] <= csr.wdata[8*b +: 8];
          end
        end
        CMD_RECOVERY_CTRL: begin
          for (int b = 0; b < 3; b++) begin
            if (byte_en[b]) rec_ctrl_q[b] <= csr.wdata[8*b +: 8];
          end
        end
        CMD_INDIRECT_FIFO_CTRL: begin
          if (word_idx_q == 3'd0) begin
            if (byte_en[0]) fifo_cms_q <= csr.wdata[7:0];
            if (byte_en[1]) fifo_reset_q <= csr.wdata[15:8];
            if (byte_en[2]) image_size_q[7:0] <= csr.wdata[23:16];
            if (byte_en[3]) image_size_q[15:8] <= csr.wdata[31:24];
          end else begin
            if (byte_en[0]) image_size_q[23:16] <= csr.wdata[7:0];
            if (byte_en[1]) image_size_q[31:24] <= csr.wdata[15:8];
          end
        end
        default: ;
      endcase
    end
  end

  // Read word for the current index
  always_comb begin
    csr.rdata = '0;
    case (cmd_q)
      CMD_DEVICE_STATUS: if (word_idx_q == 3'd0) csr.rdata = {16'h0, prot_err_q, 8'h0};
      CMD_DEVICE_RESET: if (word_idx_q == 3'd0) csr.rdata = {8'h0, dev_reset_q};
      CMD_RECOVERY_CTRL: if (word_idx_q == 3'd0) csr.rdata = {8'h0, rec_ctrl_q};
      CMD_INDIRECT_FIFO_CTRL: begin
        if (word_idx_q == 3'd0) csr.rdata = {image_size_q[15:0], fifo_reset_q, fifo_cms_q};
        else if (word_idx_q == 3'd1) csr.rdata = {16'h0, image_size_q[31:16]};
      end
      CMD_INDIRECT_FIFO_STATUS: begin
        case (word_idx_q)
          3'd0: csr.rdata = {30'h0, fifo_full_i, fifo_empty_i};
          3'd1: csr.rdata = fifo_wr_idx_i;
          3'd2: csr.rdata = fifo_rd_idx_i;
          3'd3: csr.rdata = word_t'(`REC_FIFO_DEPTH);
          3'd4: csr.rdata = word_t'(`REC_MAX_XFER_SIZE);
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  assign fifo_clr_o = (fifo_reset_q == `REC_FIFO_RESET_CODE);
  assign image_activated_o = (rec_ctrl_q[2] == `REC_ACTIVATE_CODE);

endmodule

/* recovery_indirect_fifo.sv */
// Writes while full are dropped; a clear wins over a push or pop in the same cycle
`timescale 1ns/1ps
`include "recovery_params.svh"

module recovery_indirect_fifo import recovery_pkg::*; #(
  parameter int unsigned Depth = `REC_FIFO_DEPTH
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wr_i,
  input  word_t     wdata_i,
  input  logic      clr_i,
  input  logic      image_activated_i,
  input  logic      rreq_i,
  output logic      rack_o,
  output word_t     rdata_o,
  output logic      full_o,
  output logic      empty_o,
  output fifo_idx_t wr_idx_o,
  output fifo_idx_t rd_idx_o,
  output logic      payload_available_o
);

  localparam int unsigned AW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CW = $clog2(Depth + 1);
  typedef logic [AW-1:0] ptr_t;

  word_t mem_q [Depth];
  ptr_t wr_ptr_q, rd_ptr_q;
  logic [CW-1:0] count_q;
  logic push, pop;
  logic rack_q, pa_q;
  word_t rdata_q;

  // Wrap at Depth, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full_o = (count_q == CW'(Depth));
  assign empty_o = (count_q == '0);
  assign push = wr_i && !full_o && !clr_i;
  assign pop = rreq_i && !empty_o && !clr_i;

  always_ff @(posedge clk_i) begin
    if (clr_i) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Read port answers one cycle later, zero when nothing was popped
  always_ff @(posedge clk_i) begin
    rdata_q <= pop ? mem_q[rd_ptr_q] : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rack_q <= 1'b0;
      pa_q <= 1'b0;
    end else begin
      rack_q <= rreq_i;
      if (full_o || (image_activated_i && !empty_o)) pa_q <= 1'b1;
      else if (empty_o) pa_q <= 1'b0;
    end
  end

  assign rack_o = rack_q;
  assign rdata_o = rdata_q;
  assign wr_idx_o = fifo_idx_t'(wr_ptr_q);
  assign rd_idx_o = fifo_idx_t'(rd_ptr_q);
  assign payload_available_o = pa_q;

  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (32'(wr_ptr_q) < Depth) && (32'(rd_ptr_q) < Depth));

endmodule

/* recovery_tx_serializer.sv */
// Byte order is little endian within each word; rd_len must be nonzero while active
`timescale 1ns/1ps

module recovery_tx_serializer import recovery_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   active_i,
  input  logic   res_dready_i,
  rec_csr_if.ser csr,
  output byte_t  res_data_o,
  output logic   res_dlast_o,
  output logic   last_beat_o
);

  len_t bcnt_q;
  logic accepted;

  // Valid is high for the whole time we are active
  assign accepted = active_i && res_dready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bcnt_q <= '0;
    end else if (!active_i) begin
      bcnt_q <= '0;
    end else if (accepted) begin
      bcnt_q <= bcnt_q + 1'b1;
    end
  end

  // Selected straight from the bank word, so no stale byte at a word boundary
  assign res_data_o = csr.rdata[8*bcnt_q[1:0] +: 8];

  assign csr.rd_next = accepted && (bcnt_q[1:0] == 2'd3);
  assign res_dlast_o = active_i && (bcnt_q == csr.rd_len - 1'b1);
  assign last_beat_o = res_dlast_o && res_dready_i;

  // Held byte must not move even though the word comes from the bank
  a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (active_i && !res_dready_i) ##1 active_i |-> $stable(res_data_o));

endmodule

/* recovery_executor.sv */
// Single command in flight; FIFO_DATA is write only and drains through the FIFO read port
`timescale 1ns/1ps

module recovery_executor import recovery_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmd_valid_i,
  input  logic      cmd_is_rd_i,
  input  cmd_code_t cmd_code_i,
  input  len_t      cmd_len_i,
  input  logic      cmd_error_i,
  output logic      cmd_done_o,
  output logic      res_valid_o,
  input  logic      res_ready_i,
  output len_t      res_len_o,
  output logic      res_dvalid_o,
  input  logic      res_dready_i,
  output byte_t     res_data_o,
  output logic      res_dlast_o,
  output logic      tti_rx_rreq_o,
  input  logic      tti_rx_rack_i,
  input  word_t     tti_rx_rdata_i,
  output logic      rx_queue_clr_o,
  input  logic      fifo_rreq_i,
  output logic      fifo_rack_o,
  output word_t     fifo_rdata_o,
  input  logic      host_abort_i,
  input  logic      recovery_mode_i,
  output logic      payload_available_o,
  output logic      image_activated_o
);

  rec_csr_if csr_if ();

  logic fifo_wr, fifo_clr, fifo_full, fifo_empty, last_beat;
  word_t fifo_wdata;
  fifo_idx_t fifo_wr_idx, fifo_rd_idx;

  assign res_len_o = csr_if.rd_len;

  recovery_ctrl u_ctrl (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_is_rd_i, .cmd_code_i, .cmd_len_i, .cmd_error_i,
    .cmd_done_o, .recovery_mode_i, .host_abort_i, .tti_rx_rreq_o, .tti_rx_rack_i,
    .tti_rx_rdata_i, .rx_queue_clr_o, .res_valid_o, .res_ready_i, .res_dvalid_o,
    .res_dready_i, .last_beat_i(last_beat), .fifo_wr_o(fifo_wr), .fifo_wdata_o(fifo_wdata),
    .csr(csr_if.ctrl)
  );

  recovery_csr_bank u_bank (
    .clk_i, .rst_ni, .csr(csr_if.bank), .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty),
    .fifo_wr_idx_i(fifo_wr_idx), .fifo_rd_idx_i(fifo_rd_idx), .fifo_clr_o(fifo_clr),
    .image_activated_o
  );

  recovery_indirect_fifo u_fifo (
    .clk_i, .rst_ni, .wr_i(fifo_wr), .wdata_i(fifo_wdata), .clr_i(fifo_clr),
    .image_activated_i(image_activated_o), .rreq_i(fifo_rreq_i), .rack_o(fifo_rack_o),
    .rdata_o(fifo_rdata_o), .full_o(fifo_full), .empty_o(fifo_empty),
    .wr_idx_o(fifo_wr_idx), .rd_idx_o(fifo_rd_idx), .payload_available_o
  );

  // Streams while the controller holds data valid
  recovery_tx_serializer u_ser (
    .clk_i, .rst_ni, .active_i(res_dvalid_o), .res_dready_i, .csr(csr_if.ser),
    .res_data_o, .res_dlast_o, .last_beat_o(last_beat)
  );

endmodule

/* tb_recovery_executor.sv */
// Tests run in a fixed order and share register state; the receive-queue model serves one request at a time
`timescale 1ns/1ps
`include "recovery_params.svh"

module tb_recovery_executor import recovery_pkg::*; ();

  localparam int Timeout = 400;
  localparam int Depth = `REC_FIFO_DEPTH;

  logic      clk_i;
  logic      rst_ni;
  logic      cmd_valid_i;
  logic      cmd_is_rd_i;
  cmd_code_t cmd_code_i;
  len_t      cmd_len_i;
  logic      cmd_error_i;
  logic      cmd_done_o;
  logic      res_valid_o;
  logic      res_ready_i;
  len_t      res_len_o;
  logic      res_dvalid_o;
  logic      res_dready_i;
  byte_t     res_data_o;
  logic      res_dlast_o;
  logic      tti_rx_rreq_o;
  logic      tti_rx_rack_i;
  word_t     tti_rx_rdata_i;
  logic      rx_queue_clr_o;
  logic      fifo_rreq_i;
  logic      fifo_rack_o;
  word_t     fifo_rdata_o;
  logic      host_abort_i;
  logic      recovery_mode_i;
  logic      payload_available_o;
  logic      image_activated_o;

  int    err_cnt;
  int    timeout_cnt;
  int    rx_underruns;
  int    clr_cnt;
  int    done_cycles;
  int    rx_delay;
  word_t rx_words[$];
  byte_t rd_bytes[$];
  logic  rd_lasts[$];
  byte_t exp_bytes[$];
  word_t rec_ctrl_exp;
  byte_t fifo_cms_exp;
  word_t image_size_exp;

  recovery_executor dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Receive queue, answers each request after 1 to 3 cycles
  initial begin
    rx_underruns = 0;
    tti_rx_rack_i = 1'b0;
    tti_rx_rdata_i = '0;
    forever begin
      @(negedge clk_i);
      tti_rx_rack_i = 1'b0;
      if (tti_rx_rreq_o === 1'b1) begin
        rx_delay = $urandom_range(1, 3);
        repeat (rx_delay) @(negedge clk_i);
        if (rx_words.size() == 0) begin
          rx_underruns++;
          $display("The DUT requested a receive-queue word when none was queued");
          tti_rx_rdata_i = '0;
        end else begin
          tti_rx_rdata_i = rx_words.pop_front();
        end
        tti_rx_rack_i = 1'b1;
      end
    end
  end

  // Count rx_queue_clr_o pulses
  initial begin
    clr_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (rx_queue_clr_o === 1'b1) clr_cnt++;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic issue_cmd(input logic is_rd, input cmd_code_t code, input len_t len,
                           input logic err);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_is_rd_i = is_rd;
    cmd_code_i = code;
    cmd_len_i = len;
    cmd_error_i = err;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    cmd_error_i = 1'b0;
  endtask

  task automatic wait_done();
    done_cycles = 0;
    while ((cmd_done_o !== 1'b1) && (done_cycles < Timeout)) begin
      @(negedge clk_i);
      done_cycles++;
    end
    assert (cmd_done_o === 1'b1) else begin
      timeout_cnt++;
      $display("Timeout: no cmd_done_o pulse within %0d cycles", Timeout);
    end
  endtask

  // Caller queues the payload words first
  task automatic write_cmd(input cmd_code_t code, input len_t len);
    issue_cmd(1'b0, code, len, 1'b0);
    wait_done();
    check_value("unused receive-queue words", rx_words.size(), 0);
  endtask

  // abort_at above zero raises host_abort_i after that many bytes
  task automatic read_cmd(input cmd_code_t code, input int exp_len, input int abort_at);
    int   cnt;
    logic stop;
    rd_bytes.delete();
    rd_lasts.delete();
    issue_cmd(1'b1, code, '0, 1'b0);
    cnt = 0;
    while ((res_valid_o !== 1'b1) && (cnt < Timeout)) begin
      @(negedge clk_i);
      cnt++;
    end
    assert (res_valid_o === 1'b1) else begin
      timeout_cnt++;
      $display("Timeout: res_valid_o never rose for command %0d", code);
    end
    check_value("res_len_o", res_len_o, exp_len);
    repeat ($urandom_range(0, 2)) @(negedge clk_i);
    check_value("res_valid_o held before ready", res_valid_o, 1);
    res_ready_i = 1'b1;
    @(negedge clk_i);
    res_ready_i = 1'b0;
    stop = 1'b0;
    cnt = 0;
    while (!stop && (cnt < Timeout)) begin
      if ((abort_at > 0) && (rd_bytes.size() == abort_at)) begin
        host_abort_i = 1'b1;
        res_dready_i = 1'b0;
        stop = 1'b1;
      end else begin
        // Back-pressure roughly one cycle in four
        res_dready_i = ($urandom_range(0, 3) != 0);
        if (res_dvalid_o && res_dready_i) begin
          rd_bytes.push_back(res_data_o);
          rd_lasts.push_back(res_dlast_o);
          stop = (rd_bytes.size() == exp_len);
        end
      end
      @(negedge clk_i);
      cnt++;
    end
    assert (stop) else begin
      timeout_cnt++;
      $display("Timeout: read stream stalled after %0d bytes", rd_bytes.size());
    end
    res_dready_i = 1'b0;
    if (host_abort_i) begin
      host_abort_i = 1'b0;
      check_value("res_dvalid_o after abort", res_dvalid_o, 0);
      check_value("rx_queue_clr_o after abort", rx_queue_clr_o, 1);
    end
    wait_done();
  endtask

  // Little-endian bytes of one word, up to the register length
  task automatic expect_word(input word_t w, input int len);
    for (int b = 0; b < 4; b++) begin
      if (exp_bytes.size() < len) exp_bytes.push_back(w[8*b +: 8]);
    end
  endtask

  task automatic expect_fifo_status(input logic empty, input logic full, input word_t wr_idx,
                                    input word_t rd_idx);
    exp_bytes.delete();
    expect_word({30'h0, full, empty}, `REC_LEN_FIFO_STATUS);
    expect_word(wr_idx, `REC_LEN_FIFO_STATUS);
    expect_word(rd_idx, `REC_LEN_FIFO_STATUS);
    expect_word(`REC_FIFO_DEPTH, `REC_LEN_FIFO_STATUS);
    expect_word(`REC_MAX_XFER_SIZE, `REC_LEN_FIFO_STATUS);
  endtask

  // RESET byte always reads back as zero
  task automatic expect_fifo_ctrl();
    exp_bytes.delete();
    expect_word({image_size_exp[15:0], 8'h00, fifo_cms_exp}, `REC_LEN_FIFO_CTRL);
    expect_word({16'h0, image_size_exp[31:16]}, `REC_LEN_FIFO_CTRL);
  endtask

  task automatic compare_read(input string what, input int count);
    check_value({what, " byte count"}, rd_bytes.size(), count);
    foreach (rd_bytes[i]) begin
      if (i < exp_bytes.size()) begin
        check_value($sformatf("%s byte %0d", what, i), rd_bytes[i], exp_bytes[i]);
        check_value($sformatf("%s dlast at byte %0d", what, i), rd_lasts[i],
                    i == exp_bytes.size() - 1);
      end
    end
  endtask

  task automatic illegal_cmd(input logic is_rd, input cmd_code_t code, input logic err,
                             input string what);
    int clr_start;
    clr_start = clr_cnt;
    issue_cmd(is_rd, code, '0, err);
    wait_done();
    check_value({what, " cycles to cmd_done_o"}, done_cycles + 1, 2);
    check_value({what, " rx_queue_clr_o pulses"}, clr_cnt - clr_start, 1);
  endtask

  task automatic pop_fifo(output word_t w);
    @(negedge clk_i);
    fifo_rreq_i = 1'b1;
    @(negedge clk_i);
    fifo_rreq_i = 1'b0;
    check_value("fifo_rack_o one cycle after request", fifo_rack_o, 1);
    w = fifo_rdata_o;
  endtask

  task automatic test_recovery_ctrl();
    byte_t b0;
    byte_t b1;
    b0 = byte_t'($urandom());
    b1 = byte_t'($urandom());
    rx_words.push_back({8'hA5, `REC_ACTIVATE_CODE, b1, b0});
    write_cmd(CMD_RECOVERY_CTRL, 16'd3);
    check_value("image_activated_o with byte 2 = 0F", image_activated_o, 1);
    // Leave activation off so the FIFO flag depends on fill level only
    rx_words.push_back({8'hA5, 8'h3C, b1, b0});
    write_cmd(CMD_RECOVERY_CTRL, 16'd3);
    check_value("image_activated_o with byte 2 = 3C", image_activated_o, 0);
    rec_ctrl_exp = {8'h00, 8'h3C, b1, b0};
    exp_bytes.delete();
    expect_word(rec_ctrl_exp, `REC_LEN_RECOVERY_CTRL);
    read_cmd(CMD_RECOVERY_CTRL, `REC_LEN_RECOVERY_CTRL, 0);
    compare_read("RECOVERY_CTRL", `REC_LEN_RECOVERY_CTRL);
  endtask

  task automatic test_write_overrun();
    word_t w0;
    word_t w1;
    recovery_mode_i = 1'b1;
    fifo_cms_exp = byte_t'($urandom());
    image_size_exp = $urandom();
    // Upper half of word 1 lies past the register
    rx_words.push_back({image_size_exp[15:0], 8'h00, fifo_cms_exp});
    rx_words.push_back({16'hDEAD, image_size_exp[31:16]});
    write_cmd(CMD_INDIRECT_FIFO_CTRL, 16'd8);
    w0 = $urandom();
    w1 = $urandom();
    rx_words.push_back(w0);
    rx_words.push_back(w1);
    write_cmd(CMD_DEVICE_RESET, 16'd8);
    exp_bytes.delete();
    expect_word(w0, `REC_LEN_DEVICE_RESET);
    read_cmd(CMD_DEVICE_RESET, `REC_LEN_DEVICE_RESET, 0);
    compare_read("DEVICE_RESET", `REC_LEN_DEVICE_RESET);
    expect_fifo_ctrl();
    read_cmd(CMD_INDIRECT_FIFO_CTRL, `REC_LEN_FIFO_CTRL, 0);
    compare_read("INDIRECT_FIFO_CTRL", `REC_LEN_FIFO_CTRL);
  endtask

  task automatic test_error_path();
    illegal_cmd(1'b1, CMD_DEVICE_STATUS, 1'b1, "CRC error");
    // Byte 1 carries the CRC code from the previous command
    exp_bytes.delete();
    expect_word({16'h0, 8'd4, 8'h00}, `REC_LEN_DEVICE_STATUS);
    expect_word('0, `REC_LEN_DEVICE_STATUS);
    read_cmd(CMD_DEVICE_STATUS, `REC_LEN_DEVICE_STATUS, 0);
    compare_read("DEVICE_STATUS after error", `REC_LEN_DEVICE_STATUS);
    exp_bytes.delete();
    expect_word('0, `REC_LEN_DEVICE_STATUS);
    expect_word('0, `REC_LEN_DEVICE_STATUS);
    read_cmd(CMD_DEVICE_STATUS, `REC_LEN_DEVICE_STATUS, 0);
    compare_read("DEVICE_STATUS after clean read", `REC_LEN_DEVICE_STATUS);
    recovery_mode_i = 1'b0;
    illegal_cmd(1'b1, CMD_INDIRECT_FIFO_STATUS, 1'b0, "FIFO_STATUS outside recovery");
  endtask

  task automatic test_fifo_data();
    int    n;
    word_t words[$];
    word_t w;
    recovery_mode_i = 1'b1;
    n = $urandom_range(3, 8);
    for (int i = 0; i < n; i++) begin
      w = $urandom();
      words.push_back(w);
      rx_words.push_back(w);
    end
    write_cmd(CMD_INDIRECT_FIFO_DATA, len_t'(4 * n));
    expect_fifo_status(1'b0, 1'b0, n, 0);
    read_cmd(CMD_INDIRECT_FIFO_STATUS, `REC_LEN_FIFO_STATUS, 0);
    compare_read("FIFO_STATUS after writes", `REC_LEN_FIFO_STATUS);
    check_value("payload_available_o below depth", payload_available_o, 0);
    for (int i = 0; i < n; i++) begin
      pop_fifo(w);
      check_value($sformatf("FIFO word %0d", i), w, words[i]);
    end
    words.delete();
    for (int i = 0; i < Depth; i++) begin
      w = $urandom();
      words.push_back(w);
      rx_words.push_back(w);
    end
    write_cmd(CMD_INDIRECT_FIFO_DATA, len_t'(4 * Depth));
    @(negedge clk_i);
    check_value("payload_available_o when full", payload_available_o, 1);
    // One more word while full, dropped
    rx_words.push_back(32'hBAD0_0001);
    write_cmd(CMD_INDIRECT_FIFO_DATA, 16'd4);
    for (int i = 0; i < Depth; i++) begin
      if (i == Depth - 1) check_value("payload_available_o before drain", payload_available_o, 1);
      pop_fifo(w);
      check_value($sformatf("full FIFO word %0d", i), w, words[i]);
    end
    @(negedge clk_i);
    check_value("payload_available_o after drain", payload_available_o, 0);
    pop_fifo(w);
    check_value("FIFO read when empty", w, 0);
  endtask

  task automatic test_fifo_reset();
    rx_words.push_back($urandom());
    rx_words.push_back($urandom());
    write_cmd(CMD_INDIRECT_FIFO_DATA, 16'd8);
    fifo_cms_exp = byte_t'($urandom());
    image_size_exp[15:0] = 16'($urandom());
    // Bytes 2 and 3 carry the low half of the image size
    rx_words.push_back({image_size_exp[15:0], `REC_FIFO_RESET_CODE, fifo_cms_exp});
    write_cmd(CMD_INDIRECT_FIFO_CTRL, 16'd4);
    expect_fifo_status(1'b1, 1'b0, 0, 0);
    read_cmd(CMD_INDIRECT_FIFO_STATUS, `REC_LEN_FIFO_STATUS, 0);
    compare_read("FIFO_STATUS after reset", `REC_LEN_FIFO_STATUS);
    expect_fifo_ctrl();
    read_cmd(CMD_INDIRECT_FIFO_CTRL, `REC_LEN_FIFO_CTRL, 0);
    compare_read("FIFO_CTRL after reset", `REC_LEN_FIFO_CTRL);
  endtask

  task automatic test_host_abort();
    int clr_start;
    clr_start = clr_cnt;
    expect_fifo_status(1'b1, 1'b0, 0, 0);
    read_cmd(CMD_INDIRECT_FIFO_STATUS, `REC_LEN_FIFO_STATUS, 5);
    compare_read("aborted FIFO_STATUS", 5);
    check_value("rx_queue_clr_o pulses on abort", clr_cnt - clr_start, 1);
    exp_bytes.delete();
    expect_word(rec_ctrl_exp, `REC_LEN_RECOVERY_CTRL);
    read_cmd(CMD_RECOVERY_CTRL, `REC_LEN_RECOVERY_CTRL, 0);
    compare_read("RECOVERY_CTRL after abort", `REC_LEN_RECOVERY_CTRL);
  endtask

  initial begin
    void'($urandom(32'h1aae66e5));
    err_cnt = 0;
    timeout_cnt = 0;
    rst_ni = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_is_rd_i = 1'b0;
    cmd_code_i = '0;
    cmd_len_i = '0;
    cmd_error_i = 1'b0;
    res_ready_i = 1'b0;
    res_dready_i = 1'b0;
    fifo_rreq_i = 1'b0;
    host_abort_i = 1'b0;
    recovery_mode_i = 1'b0;
    repeat (16) @(negedge clk_i);
    check_value("cmd_done_o in reset", cmd_done_o, 0);
    check_value("res_valid_o in reset", res_valid_o, 0);
    check_value("res_dvalid_o in reset", res_dvalid_o, 0);
    check_value("tti_rx_rreq_o in reset", tti_rx_rreq_o, 0);
    check_value("rx_queue_clr_o in reset", rx_queue_clr_o, 0);
    check_value("fifo_rack_o in reset", fifo_rack_o, 0);
    check_value("payload_available_o in reset", payload_available_o, 0);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_recovery_ctrl();
    test_write_overrun();
    test_error_path();
    test_fifo_data();
    test_fifo_reset();
    test_host_abort();
    $display("Check errors: %0d, timeouts: %0d, receive-queue underruns: %0d",
             err_cnt, timeout_cnt, rx_underruns);
    if ((err_cnt == 0) && (timeout_cnt == 0) && (rx_underruns == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
recovery_pkg.sv
rec_csr_if.sv
recovery_ctrl.sv
recovery_csr_bank.sv
recovery_indirect_fifo.sv
recovery_tx_serializer.sv
recovery_executor.sv
tb_recovery_executor.sv
